//--- msg_test.f
+incdir+hdl
hdl/msg_pkg.sv
hdl/msg_chnl_if.sv
hdl/msg_source.sv
hdl/msg_merge_node.sv
hdl/msg_sink.sv
hdl/msg_test_top.sv
verif/msg_test_tb.sv

//--- Makefile
# Verilator flow for the message network self-test

TB_TOP = msg_test_tb

.PHONY: all lint sim clean

all: sim

# lint the RTL top against the full file list
lint:
	verilator --lint-only --timing --assert -f msg_test.f --top-module msg_test_top

# build and run, a $$fatal in the testbench gives a failing exit status
sim:
	verilator --binary --timing --assert -j 0 -f msg_test.f \
		--top-module $(TB_TOP) -o $(TB_TOP)
	./obj_dir/$(TB_TOP)

clean:
	rm -rf obj_dir

//--- verif/msg_test_tb.sv
`timescale 1ns/1ns
`include "msg_settings.svh"

module msg_test_tb;

	localparam int CLK_PER = 40;
	localparam int N_RUNS = 4;
	localparam int RUN_MSGS = 2 * `MSG_PER_SRC;
	// runs x messages x cycles per message x period
	localparam int WDOG_NS = N_RUNS * RUN_MSGS * 20 * CLK_PER;

	logic i_clk;
	logic i_rst;
	logic i_start;
	logic i_inject;
	logic o_busy;
	logic o_done;
	logic o_err;
	logic [7:0] o_rcv_cnt;
	logic [7:0] o_fst_err_dat;

	// random state, stepped per bit
	logic [31:0] lfsr = 32'h6594_528d;
	// outcome expected from the current run
	logic exp_err = 1'b0;
	logic [7:0] exp_cnt = 8'd0;
	// rising edges of busy seen so far
	logic busy_q = 1'b0;
	int busy_runs = 0;

	msg_test_top uut
	(
		.i_clk (i_clk),
		.i_rst (i_rst),
		.i_start (i_start),
		.i_inject (i_inject),
		.o_busy (o_busy),
		.o_done (o_done),
		.o_err (o_err),
		.o_rcv_cnt (o_rcv_cnt),
		.o_fst_err_dat (o_fst_err_dat)
	);

	task automatic abort_run(input string msg);
		$display("FAIL %0t: %s", $time, msg);
		$display("STATUS: FAIL");
		$fatal(1, "check failed");
	endtask

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_bits(input int n, output int val);
		int i;
		val = 0;
		for (i = 0; i < n; i++)
		begin
			lfsr = lfsr_step(lfsr);
			val = (val << 1) | int'(lfsr[0]);
		end
	endtask

	// everything cleared one cycle after reset
	a_reset: assert property (@(posedge i_clk) i_rst |=> (!o_busy && !o_done && !o_err
		&& o_rcv_cnt == 8'd0 && o_fst_err_dat == 8'd0))
		else abort_run("outputs not cleared by reset");

	a_excl: assert property (@(posedge i_clk) disable iff (i_rst) !(o_busy && o_done))
		else abort_run("busy and done high together");

	// run ends with busy falling and done rising on the same edge
	a_done_edge: assert property (@(posedge i_clk) disable iff (i_rst)
		$fell(o_busy) == $rose(o_done))
		else abort_run("busy fall and done rise not on the same edge");

	// accepted start clears the results and raises busy
	a_start: assert property (@(posedge i_clk) disable iff (i_rst)
		(i_start && !o_busy) |=> (o_busy && !o_done && !o_err && o_rcv_cnt == 8'd0))
		else abort_run("start did not begin a fresh run");

	// no restart while busy, count only grows
	a_mono: assert property (@(posedge i_clk) disable iff (i_rst)
		o_busy |=> (o_rcv_cnt >= $past(o_rcv_cnt)))
		else abort_run("message count went backwards during a run");

	a_err_rise: assert property (@(posedge i_clk) disable iff (i_rst) $rose(o_err) |-> exp_err)
		else abort_run("error flag rose in a clean run");

	a_done_cnt: assert property (@(posedge i_clk) disable iff (i_rst)
		$rose(o_done) |-> (o_rcv_cnt == exp_cnt))
		else abort_run($sformatf("count %0d at done, expected %0d", o_rcv_cnt, exp_cnt));

	// corrupt message always comes from source 1
	a_done_err: assert property (@(posedge i_clk) disable iff (i_rst)
		$rose(o_done) |-> (o_err == exp_err
		&& (exp_err ? o_fst_err_dat[7] : o_fst_err_dat == 8'd0)))
		else abort_run($sformatf("err %0b first data %h at done", o_err, o_fst_err_dat));

	always @(posedge i_clk)
	begin
		busy_q <= o_busy;
		if (!i_rst && o_busy && !busy_q)
			busy_runs <= busy_runs + 1;
	end

	task automatic start_pulse();
		i_start <= 1'b1;
		@(posedge i_clk);
		i_start <= 1'b0;
	endtask

	// one run, optionally with a corrupt message or extra starts
	task automatic run_test(input logic with_inject, input logic extra_starts);
		int gap;
		int k;
		draw_bits(4, gap);
		repeat (gap + 1)
			@(posedge i_clk);
		exp_err <= with_inject;
		exp_cnt <= with_inject ? 8'(RUN_MSGS - 1) : 8'(RUN_MSGS);
		start_pulse();
		while (!o_busy)
			@(posedge i_clk);
		if (extra_starts)
		begin
			// well inside the run, must be ignored
			for (k = 0; k < 3; k++)
			begin
				draw_bits(3, gap);
				repeat (gap + 1)
					@(posedge i_clk);
				start_pulse();
			end
		end
		if (with_inject)
		begin
			draw_bits(3, gap);
			repeat (gap)
				@(posedge i_clk);
			i_inject <= 1'b1;
			@(posedge i_clk);
			i_inject <= 1'b0;
		end
		// watchdog covers a run that never ends
		while (!o_done)
			@(posedge i_clk);
	endtask

	initial
	begin
		i_clk = 1'b0;
		forever
			#(CLK_PER / 2) i_clk = ~i_clk;
	end

	initial
	begin
		#(WDOG_NS);
		$display("timeout: runs did not complete within %0d ns", WDOG_NS);
		$display("STATUS: FAIL");
		$fatal(1, "watchdog");
	end

	initial
	begin
		i_rst = 1'b1;
		i_start = 1'b0;
		i_inject = 1'b0;
		repeat (3)
			@(posedge i_clk);
		i_rst <= 1'b0;
		// clean, redundant starts, corrupt, clean again
		run_test(1'b0, 1'b0);
		run_test(1'b0, 1'b1);
		run_test(1'b1, 1'b0);
		run_test(1'b0, 1'b0);
		repeat (2)
			@(posedge i_clk);
		if (busy_runs == N_RUNS)
		begin
			$display("STATUS: PASS");
			$finish;
		end
		else
			abort_run($sformatf("%0d runs started, expected %0d", busy_runs, N_RUNS));
	end

endmodule

//--- hdl/msg_test_top.sv
`timescale 1ns/1ns
`include "msg_settings.svh"

module msg_test_top
(
	input logic i_clk,
	input logic i_rst,
	input logic i_start,
	input logic i_inject,
	output logic o_busy,
	output logic o_done,
	output logic o_err,
	output logic [7:0] o_rcv_cnt,
	output logic [7:0] o_fst_err_dat
);

	// ignore start while a run is going
	logic start_g;

	assign start_g = i_start && !o_busy;

	// source to node, node to sink
	msg_chnl_if lnk_0 ();
	msg_chnl_if lnk_1 ();
	msg_chnl_if lnk_out ();

	msg_source #(.SRC_ID(1'b0)) u_src0
	(
		.i_clk (i_clk),
		.i_rst (i_rst),
		.i_start (start_g),
		.o_done (),
		.i_inject (1'b0),
		.lnk (lnk_0)
	);

	// error injection on source 1 only
	msg_source #(.SRC_ID(1'b1)) u_src1
	(
		.i_clk (i_clk),
		.i_rst (i_rst),
		.i_start (start_g),
		.o_done (),
		.i_inject (i_inject),
		.lnk (lnk_1)
	);

	msg_merge_node u_node
	(
		.i_clk (i_clk),
		.i_rst (i_rst),
		.in0 (lnk_0),
		.in1 (lnk_1),
		.out (lnk_out)
	);

	// run ends when the sink has taken the last message
	msg_sink #(.MIN_ADDR(`MSG_MIN_ADDR), .MAX_ADDR(`MSG_MAX_ADDR)) u_sink
	(
		.i_clk (i_clk),
		.i_rst (i_rst),
		.i_start (start_g),
		.lnk (lnk_out),
		.o_busy (o_busy),
		.o_done (o_done),
		.o_err (o_err),
		.o_rcv_cnt (o_rcv_cnt),
		.o_fst_err_dat (o_fst_err_dat)
	);

endmodule

//--- hdl/msg_sink.sv
`timescale 1ns/1ns
`include "msg_settings.svh"

module msg_sink
#(
	parameter msg_pkg::addr_t MIN_ADDR = `MSG_MIN_ADDR,
	parameter msg_pkg::addr_t MAX_ADDR = `MSG_MAX_ADDR
)
(
	input logic i_clk,
	input logic i_rst,
	input logic i_start,
	msg_chnl_if.rcv lnk,
	output logic o_busy,
	output logic o_done,
	output logic o_err,
	output msg_pkg::cnt_t o_rcv_cnt,
	output msg_pkg::data_t o_fst_err_dat
);
	import msg_pkg::*;

	// next expected sequence number per source
	cnt_t exp_seq [2];
	// all messages seen this run, good or bad
	cnt_t tot_cnt;

	logic new_msg;
	logic red_ok;
	logic dst_ok;
	logic seq_ok;

	assign new_msg = lnk.req && !lnk.ack;
	assign red_ok = (lnk.red == ~lnk.dat);
	assign dst_ok = (lnk.dst >= MIN_ADDR) && (lnk.dst <= MAX_ADDR);
	// top bit must match the source too
	assign seq_ok = (lnk.dat == {lnk.src, exp_seq[lnk.src][`MSG_DATA_W-2:0]});

	always_ff @(posedge i_clk)
	begin
		if (i_rst)
		begin
			lnk.ack <= 1'b0;
			o_busy <= 1'b0;
			o_done <= 1'b0;
			o_err <= 1'b0;
			o_rcv_cnt <= '0;
			o_fst_err_dat <= '0;
			tot_cnt <= '0;
			exp_seq[0] <= '0;
			exp_seq[1] <= '0;
		end
		else
		begin
			// four-phase receive side
			if (new_msg)
				lnk.ack <= 1'b1;
			else if (lnk.ack && !lnk.req)
				lnk.ack <= 1'b0;

			if (i_start)
			begin
				o_busy <= 1'b1;
				o_done <= 1'b0;
				o_err <= 1'b0;
				o_rcv_cnt <= '0;
				o_fst_err_dat <= '0;
				tot_cnt <= '0;
				exp_seq[0] <= '0;
				exp_seq[1] <= '0;
			end
			else if (new_msg && o_busy)
			begin
				// step past a bad one so it does not cascade
				exp_seq[lnk.src] <= exp_seq[lnk.src] + 1'b1;
				tot_cnt <= tot_cnt + 1'b1;
				if (red_ok && dst_ok && seq_ok)
					o_rcv_cnt <= o_rcv_cnt + 1'b1;
				else if (!o_err)
				begin
					o_err <= 1'b1;
					o_fst_err_dat <= lnk.dat;
				end
				// last message of the run
				if (tot_cnt == cnt_t'(2 * `MSG_PER_SRC - 1))
				begin
					o_busy <= 1'b0;
					o_done <= 1'b1;
				end
			end
		end
	end

endmodule

//--- hdl/msg_merge_node.sv
`timescale 1ns/1ns

module msg_merge_node
(
	input logic i_clk,
	input logic i_rst,
	msg_chnl_if.rcv in0,
	msg_chnl_if.rcv in1,
	msg_chnl_if.snd out
);
	import msg_pkg::*;

	// capture register between the stages
	logic cap_vld;
	src_id_t cap_src;
	addr_t cap_dst;
	data_t cap_dat;
	red_t cap_red;

	// input served last, loses the next tie
	logic last_in;

	node_state_t out_st;

	// new requests not yet acknowledged
	logic pend0;
	logic pend1;
	logic gnt0;
	logic gnt1;
	// output stage takes the capture
	logic take;

	assign pend0 = in0.req && !in0.ack;
	assign pend1 = in1.req && !in1.ack;
	// grant only into an empty capture
	assign gnt0 = !cap_vld && pend0 && (!pend1 || last_in);
	assign gnt1 = !cap_vld && pend1 && (!pend0 || !last_in);
	assign take = cap_vld && (out_st == OUT_IDLE);

	// input stage
	always_ff @(posedge i_clk)
	begin
		if (i_rst)
		begin
			cap_vld <= 1'b0;
			last_in <= 1'b1;
			in0.ack <= 1'b0;
			in1.ack <= 1'b0;
		end
		else
		begin
			// drop ack once the sender released req
			if (in0.ack && !in0.req)
				in0.ack <= 1'b0;
			if (in1.ack && !in1.req)
				in1.ack <= 1'b0;
			if (gnt0)
			begin
				in0.ack <= 1'b1;
				last_in <= 1'b0;
				cap_vld <= 1'b1;
			end
			else if (gnt1)
			begin
				in1.ack <= 1'b1;
				last_in <= 1'b1;
				cap_vld <= 1'b1;
			end
			else if (take)
				cap_vld <= 1'b0;
		end
	end

	// capture payload, no reset
	always_ff @(posedge i_clk)
	begin
		if (gnt0)
		begin
			cap_src <= in0.src;
			cap_dst <= in0.dst;
			cap_dat <= in0.dat;
			cap_red <= in0.red;
		end
		else if (gnt1)
		begin
			cap_src <= in1.src;
			cap_dst <= in1.dst;
			cap_dat <= in1.dat;
			cap_red <= in1.red;
		end
	end

	// output stage, runs the outgoing handshake
	always_ff @(posedge i_clk)
	begin
		if (i_rst)
		begin
			out_st <= OUT_IDLE;
			out.req <= 1'b0;
		end
		else
		begin
			case (out_st)
				OUT_IDLE:
				begin
					if (take)
					begin
						// fields pass through untouched
						out.src <= cap_src;
						out.dst <= cap_dst;
						out.dat <= cap_dat;
						out.red <= cap_red;
						out.req <= 1'b1;
						out_st <= OUT_REQ;
					end
				end
				OUT_REQ:
				begin
					if (out.ack)
					begin
						out.req <= 1'b0;
						out_st <= OUT_REL;
					end
				end
				OUT_REL:
				begin
					// wait for ack low before the next req
					if (!out.ack)
						out_st <= OUT_IDLE;
				end
				default: out_st <= OUT_IDLE;
			endcase
		end
	end

endmodule

//--- hdl/msg_source.sv
`timescale 1ns/1ns
`include "msg_settings.svh"

module msg_source
#(
	parameter msg_pkg::src_id_t SRC_ID = 1'b0
)
(
	input logic i_clk,
	input logic i_rst,
	input logic i_start,
	output logic o_done,
	input logic i_inject,
	msg_chnl_if.snd lnk
);
	import msg_pkg::*;

	src_state_t state;
	// sequence number of the message in flight
	cnt_t seq;
	// next message gets a bad redundancy byte
	logic inj_armed;
	data_t nxt_dat;

	// source id in the top bit, sequence below
	assign nxt_dat = {SRC_ID, seq[`MSG_DATA_W-2:0]};

	always_ff @(posedge i_clk)
	begin
		if (i_rst)
		begin
			state <= IDLE;
			seq <= '0;
			inj_armed <= 1'b0;
			o_done <= 1'b0;
			lnk.req <= 1'b0;
		end
		else
		begin
			o_done <= 1'b0;
			// arm only while a run is going
			if (i_inject && state != IDLE)
				inj_armed <= 1'b1;
			case (state)
				IDLE:
				begin
					inj_armed <= 1'b0;
					if (i_start)
					begin
						seq <= '0;
						lnk.dst <= addr_t'(`MSG_MIN_ADDR);
						state <= SEND;
					end
				end
				SEND:
				begin
					// fields and req together, ack is low here
					lnk.src <= SRC_ID;
					lnk.dat <= nxt_dat;
					lnk.red <= inj_armed ? nxt_dat : ~nxt_dat;
					inj_armed <= i_inject;
					lnk.req <= 1'b1;
					state <= WAIT_ACK;
				end
				WAIT_ACK:
				begin
					// back-pressure holds us here
					if (lnk.ack)
					begin
						lnk.req <= 1'b0;
						state <= WAIT_REL;
					end
				end
				WAIT_REL:
				begin
					if (!lnk.ack)
					begin
						if (seq == cnt_t'(`MSG_PER_SRC - 1))
						begin
							o_done <= 1'b1;
							state <= IDLE;
						end
						else
						begin
							seq <= seq + 1'b1;
							// walk the destination range
							if (lnk.dst == addr_t'(`MSG_MAX_ADDR))
								lnk.dst <= addr_t'(`MSG_MIN_ADDR);
							else
								lnk.dst <= lnk.dst + 1'b1;
							state <= SEND;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

//--- hdl/msg_chnl_if.sv
`timescale 1ns/1ns

// four-phase req/ack link carrying one message
interface msg_chnl_if;
	import msg_pkg::*;

	// handshake pair
	logic req;
	logic ack;

	// payload, stable while req is high
	src_id_t src;
	addr_t dst;
	data_t dat;
	red_t red;

	// sending end
	modport snd
	(
		output req, src, dst, dat, red,
		input ack
	);

	// receiving end
	modport rcv
	(
		input req, src, dst, dat, red,
		output ack
	);

endinterface

//--- hdl/msg_pkg.sv
`include "msg_settings.svh"

package msg_pkg;

	// message fields
	typedef logic [`MSG_ADDR_W-1:0] addr_t;
	typedef logic [`MSG_DATA_W-1:0] data_t;
	// complement of data when the message is good
	typedef logic [`MSG_DATA_W-1:0] red_t;
	typedef logic [0:0] src_id_t;

	// message and sequence counter
	typedef logic [`MSG_CNT_W-1:0] cnt_t;

	// source handshake states
	typedef enum logic [1:0]
	{
		IDLE,
		SEND,
		WAIT_ACK,
		WAIT_REL
	} src_state_t;

	// node output stage states
	typedef enum logic [1:0]
	{
		OUT_IDLE,
		OUT_REQ,
		OUT_REL
	} node_state_t;

endpackage

//--- hdl/msg_settings.svh
`ifndef MSG_SETTINGS_SVH
`define MSG_SETTINGS_SVH

// destination address width
`define MSG_ADDR_W 4

// data and redundancy width
`define MSG_DATA_W 8

// sink accepts destinations in this range
`define MSG_MIN_ADDR 3
`define MSG_MAX_ADDR 9

// messages each source sends per run
`define MSG_PER_SRC 16

// counter width, must hold 2 x MSG_PER_SRC
`define MSG_CNT_W 8

`endif
